// ==== files.f ====
logic/pipe_pkg.sv
logic/pipe_gprs.sv
logic/pipe_hazard.sv
logic/pipe_decode.sv
logic/pipe_execute.sv
logic/pipe_memory.sv
logic/pipe_writeback.sv
logic/pipe_top.sv
sim/pipe_asserts.sv
sim/pipe_tb.sv

// ==== logic/pipe_decode.sv ====
/*
 * Decode / operand read stage
 * Holds the issued op and builds the execute payload from forwarded operands
 */
`timescale 1ns/10ps
`default_nettype none

module pipe_decode import pipe_pkg::*; (
    input  logic      g_clk,
    input  logic      rst_n,
    input  logic      in_valid,       // Issue request
    input  issue_op_t in_op,
    output logic      in_ready,       // Empty or advancing
    output reg_addr_t s1_rs1,         // Source indices to hazard unit
    output reg_addr_t s1_rs2,
    output logic      s1_need,        // s1 holds an op
    input  word_t     fwd_rs1_rdata,  // Forwarded operands
    input  word_t     fwd_rs2_rdata,
    input  logic      s1_bubble,      // Load-use stall
    output logic      s2_valid,
    output stage_op_t s2_op,
    input  logic      s2_busy
);

    logic      s1_valid_q;  // s1 occupied
    issue_op_t s1_op_q;     // Held op
    logic      s1_adv;      // Moving into s2 this cycle
    logic      s1_take;     // Accepting a new op

    assign s1_adv   = s2_valid && !s2_busy;
    assign in_ready = !s1_valid_q || s1_adv;
    assign s1_take  = in_valid && in_ready;

    always_ff @(posedge g_clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid_q <= 1'b0;
        end else if (s1_take) begin
            s1_valid_q <= 1'b1;     // Refill, possibly in the same cycle it drains
        end else if (s1_adv) begin
            s1_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge g_clk) begin
        if (s1_take) begin
            s1_op_q <= in_op;
        end
    end

    assign s1_rs1  = s1_op_q.rs1;
    assign s1_rs2  = s1_op_q.rs2;
    assign s1_need = s1_valid_q;

    // Bubble keeps the op here and shows s2 nothing
    assign s2_valid = s1_valid_q && !s1_bubble;

    always_comb begin
        s2_op.uop   = s1_op_q.uop;
        s2_op.rd    = s1_op_q.rd;
        s2_op.opr_a = fwd_rs1_rdata;  // rs1 value
        s2_op.opr_b = fwd_rs2_rdata;  // rs2 value, store data
        s2_op.imm   = s1_op_q.imm;
    end

endmodule

`default_nettype wire

// ==== logic/pipe_execute.sv ====
/*
 * Execute stage
 * ALU and load/store address arithmetic on the s2 register
 */
`timescale 1ns/10ps
`default_nettype none

module pipe_execute import pipe_pkg::*; (
    input  logic      g_clk,
    input  logic      rst_n,
    input  logic      s2_valid,
    input  stage_op_t s2_op,
    output logic      s2_busy,
    output fwd_t      fwd_s2,    // Result offered to decode
    output logic      s3_valid,
    output stage_op_t s3_op,
    input  logic      s3_busy
);

    logic      s2_valid_q;
    stage_op_t s2_op_q;
    word_t     imm_ext;     // Sign extended immediate
    word_t     result;

    assign s2_busy = s2_valid_q && s3_busy;

    always_ff @(posedge g_clk or negedge rst_n) begin
        if (!rst_n) begin
            s2_valid_q <= 1'b0;
        end else if (!s2_busy) begin
            s2_valid_q <= s2_valid;  // Bubble loads as empty
        end
    end

    always_ff @(posedge g_clk) begin
        if (!s2_busy && s2_valid) begin
            s2_op_q <= s2_op;
        end
    end

    // ALU ----------------------------------
    assign imm_ext = {{(XLEN - IMM_W){s2_op_q.imm[IMM_W-1]}}, s2_op_q.imm};

    always_comb begin
        case (s2_op_q.uop)
            UOP_ADD: result = s2_op_q.opr_a + s2_op_q.opr_b;
            UOP_SUB: result = s2_op_q.opr_a - s2_op_q.opr_b;
            UOP_AND: result = s2_op_q.opr_a & s2_op_q.opr_b;
            UOP_XOR: result = s2_op_q.opr_a ^ s2_op_q.opr_b;
            default: result = s2_op_q.opr_a + imm_ext;  // ADDI, load/store address
        endcase
    end

    assign s3_valid = s2_valid_q;

    always_comb begin
        s3_op       = s2_op_q;
        s3_op.opr_a = result;        // opr_b keeps store data
    end

    assign fwd_s2.valid = s2_valid_q && (s2_op_q.uop != UOP_STORE);
    assign fwd_s2.rd    = s2_op_q.rd;
    assign fwd_s2.wdata = result;
    assign fwd_s2.load  = s2_op_q.uop == UOP_LOAD;  // Address only, data later

endmodule

`default_nettype wire

// ==== logic/pipe_gprs.sv ====
/*
 * General purpose register file
 * Two combinational read ports, one write port, register zero fixed at zero
 */
`timescale 1ns/10ps
`default_nettype none

module pipe_gprs import pipe_pkg::*; (
    input  logic      g_clk,
    input  logic      rst_n,
    input  reg_addr_t rs1_addr,
    input  reg_addr_t rs2_addr,
    output word_t     rs1_data,
    output word_t     rs2_data,
    input  logic      gpr_wen,    // Write strobe from writeback
    input  reg_addr_t gpr_rd,
    input  word_t     gpr_wdata
);

    word_t regs [NREGS];

    always_ff @(posedge g_clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (gpr_wen && (gpr_rd != '0)) begin
            regs[gpr_rd] <= gpr_wdata;      // x0 never written
        end
    end

    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire

// ==== logic/pipe_hazard.sv ====
/*
 * Hazard and forwarding unit
 * Picks the youngest producer of each decode source, stalls on load-use
 */
`timescale 1ns/10ps
`default_nettype none

module pipe_hazard import pipe_pkg::*; (
    input  reg_addr_t s1_rs1,
    input  reg_addr_t s1_rs2,
    input  logic      s1_need,        // Decode holds an op
    input  word_t     rs1_rdata,      // Register file data
    input  word_t     rs2_rdata,
    input  fwd_t      fwd_s2,         // Execute
    input  fwd_t      fwd_s3,         // Memory
    input  fwd_t      fwd_s4,         // Writeback
    output word_t     fwd_rs1_rdata,
    output word_t     fwd_rs2_rdata,
    output logic      s1_bubble
);

    // Register zero never matches
    function automatic logic hit(reg_addr_t rs, fwd_t f);
        return (rs != '0) && f.valid && (f.rd == rs);
    endfunction

    // Youngest stage first, register file last
    function automatic word_t pick(reg_addr_t rs, word_t rf_data);
        word_t d;
        if (hit(rs, fwd_s2)) begin
            d = fwd_s2.wdata;
        end else if (hit(rs, fwd_s3)) begin
            d = fwd_s3.wdata;
        end else if (hit(rs, fwd_s4)) begin
            d = fwd_s4.wdata;
        end else begin
            d = rf_data;
        end
        return d;
    endfunction

    assign fwd_rs1_rdata = pick(s1_rs1, rs1_rdata);
    assign fwd_rs2_rdata = pick(s1_rs2, rs2_rdata);

    // Load in execute has no data yet
    assign s1_bubble = s1_need && fwd_s2.load &&
                       (hit(s1_rs1, fwd_s2) || hit(s1_rs2, fwd_s2));

endmodule

`default_nettype wire

// ==== logic/pipe_memory.sv ====
/*
 * Memory stage
 * Local word-addressed data memory, combinational load and store on advance
 */
`timescale 1ns/10ps
`default_nettype none

module pipe_memory import pipe_pkg::*; (
    input  logic      g_clk,
    input  logic      rst_n,
    input  logic      s3_valid,
    input  stage_op_t s3_op,
    output logic      s3_busy,
    output fwd_t      fwd_s3,    // Result offered to decode
    output logic      s4_valid,
    output stage_op_t s4_op,
    input  logic      s4_busy
);

    logic               s3_valid_q;
    stage_op_t          s3_op_q;
    word_t              dmem [DMEM_WORDS];
    logic [DMEM_AW-1:0] dmem_idx;     // Word index from byte address
    logic               s3_adv;
    logic               is_load;
    logic               is_store;

    assign s3_busy  = s3_valid_q && s4_busy;
    assign s3_adv   = s3_valid_q && !s4_busy;
    assign is_load  = s3_op_q.uop == UOP_LOAD;
    assign is_store = s3_op_q.uop == UOP_STORE;
    assign dmem_idx = s3_op_q.opr_a[DMEM_AW+1:2];

    always_ff @(posedge g_clk or negedge rst_n) begin
        if (!rst_n) begin
            s3_valid_q <= 1'b0;
        end else if (!s3_busy) begin
            s3_valid_q <= s3_valid;
        end
    end

    always_ff @(posedge g_clk) begin
        if (!s3_busy && s3_valid) begin
            s3_op_q <= s3_op;
        end
    end

    // Data memory ---------------------------
    always_ff @(posedge g_clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DMEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
        end else if (s3_adv && is_store) begin
            dmem[dmem_idx] <= s3_op_q.opr_b;  // Written once, as it leaves s3
        end
    end

    assign s4_valid = s3_valid_q;

    always_comb begin
        s4_op = s3_op_q;
        if (is_load) begin
            s4_op.opr_a = dmem[dmem_idx];     // Async read
        end else if (is_store) begin
            s4_op.opr_a = s3_op_q.opr_b;      // Store data as result
        end
    end

    assign fwd_s3.valid = s3_valid_q && !is_store;
    assign fwd_s3.rd    = s3_op_q.rd;
    assign fwd_s3.wdata = s4_op.opr_a;  // Load data already known here
    assign fwd_s3.load  = 1'b0;

endmodule

`default_nettype wire

// ==== logic/pipe_pkg.sv ====
/*
 * Pipeline package
 * Widths, the micro-op encoding and the structs passed between stages
 */
`default_nettype none

package pipe_pkg;

    // Widths --------------------------------
    localparam int XLEN       = 32;            // Data width
    localparam int REG_AW     = 4;             // Register index width
    localparam int DMEM_AW    = 4;             // Data memory word index width
    localparam int IMM_W      = 16;            // Immediate width, sign extended
    localparam int NREGS      = 2 ** REG_AW;   // Register file depth
    localparam int DMEM_WORDS = 2 ** DMEM_AW;  // Local data memory depth

    typedef logic [XLEN-1:0]   word_t;
    typedef logic [REG_AW-1:0] reg_addr_t;
    typedef logic [IMM_W-1:0]  imm_t;

    // Pre-decoded operation
    typedef enum logic [2:0] {
        UOP_ADD,
        UOP_SUB,
        UOP_AND,
        UOP_XOR,
        UOP_ADDI,
        UOP_LOAD,
        UOP_STORE
    } uop_e;

    // Stage payloads ------------------------
    typedef struct packed {
        uop_e      uop;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        imm_t      imm;
    } issue_op_t;

    typedef struct packed {
        uop_e      uop;
        reg_addr_t rd;
        word_t     opr_a;  // Source A, then the result
        word_t     opr_b;  // Source B, store data
        imm_t      imm;
    } stage_op_t;

    typedef struct packed {
        logic      valid;  // Stage will write rd
        reg_addr_t rd;
        word_t     wdata;
        logic      load;   // Data not known yet
    } fwd_t;

    typedef struct packed {
        uop_e      uop;
        reg_addr_t rd;
        word_t     wdata;
    } retire_t;

endpackage

`default_nettype wire

// ==== logic/pipe_top.sv ====
/*
 * Pipeline top level
 * Four stage in-order integer pipeline: decode, execute, memory, writeback
 */
`timescale 1ns/10ps
`default_nettype none

module pipe_top import pipe_pkg::*; (
    input  logic      g_clk,      // Global clock
    input  logic      rst_n,      // Async reset, active low
    input  logic      in_valid,   // Issue request
    input  issue_op_t in_op,      // Issued operation
    output logic      in_ready,   // Decode can take an op
    output logic      trs_valid,  // Retire record valid
    output retire_t   trs_rec,    // Retire record
    input  logic      trs_ready   // Trace sink accepts
);

    // Stage chain ---------------------------
    logic      s2_valid;
    stage_op_t s2_op;
    logic      s2_busy;
    logic      s3_valid;
    stage_op_t s3_op;
    logic      s3_busy;
    logic      s4_valid;
    stage_op_t s4_op;
    logic      s4_busy;

    // Operand read and forwarding -----------
    reg_addr_t s1_rs1;         // Decode source 1 index
    reg_addr_t s1_rs2;         // Decode source 2 index
    logic      s1_need;        // Decode holds an op
    word_t     rs1_rdata;      // Raw register file data
    word_t     rs2_rdata;
    word_t     fwd_rs1_rdata;  // After forwarding
    word_t     fwd_rs2_rdata;
    logic      s1_bubble;      // Load-use stall
    fwd_t      fwd_s2;
    fwd_t      fwd_s3;
    fwd_t      fwd_s4;

    logic      gpr_wen;
    reg_addr_t gpr_rd;
    word_t     gpr_wdata;

    pipe_decode u_decode (
        .g_clk         (g_clk),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .in_op         (in_op),
        .in_ready      (in_ready),
        .s1_rs1        (s1_rs1),
        .s1_rs2        (s1_rs2),
        .s1_need       (s1_need),
        .fwd_rs1_rdata (fwd_rs1_rdata),
        .fwd_rs2_rdata (fwd_rs2_rdata),
        .s1_bubble     (s1_bubble),
        .s2_valid      (s2_valid),
        .s2_op         (s2_op),
        .s2_busy       (s2_busy)
    );

    pipe_hazard u_hazard (
        .s1_rs1        (s1_rs1),
        .s1_rs2        (s1_rs2),
        .s1_need       (s1_need),
        .rs1_rdata     (rs1_rdata),
        .rs2_rdata     (rs2_rdata),
        .fwd_s2        (fwd_s2),
        .fwd_s3        (fwd_s3),
        .fwd_s4        (fwd_s4),
        .fwd_rs1_rdata (fwd_rs1_rdata),
        .fwd_rs2_rdata (fwd_rs2_rdata),
        .s1_bubble     (s1_bubble)
    );

    pipe_gprs u_gprs (
        .g_clk     (g_clk),
        .rst_n     (rst_n),
        .rs1_addr  (s1_rs1),
        .rs2_addr  (s1_rs2),
        .rs1_data  (rs1_rdata),
        .rs2_data  (rs2_rdata),
        .gpr_wen   (gpr_wen),
        .gpr_rd    (gpr_rd),
        .gpr_wdata (gpr_wdata)
    );

    pipe_execute u_execute (
        .g_clk    (g_clk),
        .rst_n    (rst_n),
        .s2_valid (s2_valid),
        .s2_op    (s2_op),
        .s2_busy  (s2_busy),
        .fwd_s2   (fwd_s2),
        .s3_valid (s3_valid),
        .s3_op    (s3_op),
        .s3_busy  (s3_busy)
    );

    pipe_memory u_memory (
        .g_clk    (g_clk),
        .rst_n    (rst_n),
        .s3_valid (s3_valid),
        .s3_op    (s3_op),
        .s3_busy  (s3_busy),
        .fwd_s3   (fwd_s3),
        .s4_valid (s4_valid),
        .s4_op    (s4_op),
        .s4_busy  (s4_busy)
    );

    pipe_writeback u_writeback (
        .g_clk     (g_clk),
        .rst_n     (rst_n),
        .s4_valid  (s4_valid),
        .s4_op     (s4_op),
        .s4_busy   (s4_busy),
        .fwd_s4    (fwd_s4),
        .gpr_wen   (gpr_wen),
        .gpr_rd    (gpr_rd),
        .gpr_wdata (gpr_wdata),
        .trs_valid (trs_valid),
        .trs_rec   (trs_rec),
        .trs_ready (trs_ready)
    );

endmodule

`default_nettype wire

// ==== logic/pipe_writeback.sv ====
/*
 * Writeback stage
 * Offers each result as a trace record and writes rd when it is taken
 */
`timescale 1ns/10ps
`default_nettype none

module pipe_writeback import pipe_pkg::*; (
    input  logic      g_clk,
    input  logic      rst_n,
    input  logic      s4_valid,
    input  stage_op_t s4_op,
    output logic      s4_busy,
    output fwd_t      fwd_s4,     // Result offered to decode
    output logic      gpr_wen,
    output reg_addr_t gpr_rd,
    output word_t     gpr_wdata,
    output logic      trs_valid,
    output retire_t   trs_rec,
    input  logic      trs_ready
);

    logic      s4_valid_q;
    stage_op_t s4_op_q;
    logic      is_store;
    logic      trs_fire;     // Record taken this cycle

    assign is_store = s4_op_q.uop == UOP_STORE;
    assign trs_fire = trs_valid && trs_ready;
    assign s4_busy  = trs_valid && !trs_ready;  // Holds the whole chain

    always_ff @(posedge g_clk or negedge rst_n) begin
        if (!rst_n) begin
            s4_valid_q <= 1'b0;
        end else if (!s4_busy) begin
            s4_valid_q <= s4_valid;
        end
    end

    always_ff @(posedge g_clk) begin
        if (!s4_busy && s4_valid) begin
            s4_op_q <= s4_op;
        end
    end

    // Trace port ---------------------------
    assign trs_valid     = s4_valid_q;
    assign trs_rec.uop   = s4_op_q.uop;
    assign trs_rec.rd    = is_store ? '0 : s4_op_q.rd;  // Stores write nothing
    assign trs_rec.wdata = s4_op_q.opr_a;

    // Register write on the retire edge only
    assign gpr_wen   = trs_fire && !is_store && (s4_op_q.rd != '0);
    assign gpr_rd    = s4_op_q.rd;
    assign gpr_wdata = s4_op_q.opr_a;

    assign fwd_s4.valid = s4_valid_q && !is_store;
    assign fwd_s4.rd    = s4_op_q.rd;
    assign fwd_s4.wdata = s4_op_q.opr_a;
    assign fwd_s4.load  = 1'b0;

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the pipeline testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert \
    -f files.f \
    --top-module pipe_tb \
    --Mdir "$OBJ_DIR" \
    -o pipe_tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ_DIR/pipe_tb_sim" +verilator+error+limit+100 > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^Verification passed$" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// ==== sim/pipe_asserts.sv ====
/*
 * Trace port protocol checks
 * Bound into the pipeline top level, watches the retire handshake
 */
`timescale 1ns/10ps
`default_nettype none

module pipe_asserts import pipe_pkg::*; (
    input logic    g_clk,
    input logic    rst_n,
    input logic    trs_valid,
    input retire_t trs_rec,
    input logic    trs_ready
);

    int fail_cnt = 0;  // Failed assertion count

    // Record frozen while the sink stalls
    a_rec_stable: assert property (
        @(posedge g_clk) disable iff (!rst_n)
        (trs_valid && !trs_ready) |=> $stable(trs_rec)
    ) else begin
        fail_cnt++;
        $error("trace record changed while waiting for trs_ready");
    end

    // Valid never withdrawn before transfer
    a_valid_hold: assert property (
        @(posedge g_clk) disable iff (!rst_n)
        (trs_valid && !trs_ready) |=> trs_valid
    ) else begin
        fail_cnt++;
        $error("trs_valid dropped before the record transferred");
    end

    a_reset_idle: assert property (
        @(posedge g_clk) $rose(rst_n) |-> !trs_valid
    ) else begin
        fail_cnt++;
        $error("trs_valid high in the first cycle after reset");
    end

endmodule

bind pipe_top pipe_asserts u_asserts (
    .g_clk     (g_clk),
    .rst_n     (rst_n),
    .trs_valid (trs_valid),
    .trs_rec   (trs_rec),
    .trs_ready (trs_ready)
);

`default_nettype wire

// ==== sim/pipe_tb.sv ====
/*
 * Pipeline testbench
 * Directed and random op streams, in-order reference model, trace checker
 */
`timescale 1ns/10ps
`default_nettype none

module pipe_tb import pipe_pkg::*;;

    localparam int CLK_PERIOD      = 100;
    localparam int N_DIRECTED      = 30;
    localparam int N_RANDOM        = 300;
    localparam int TOTAL_OPS       = N_DIRECTED + N_RANDOM;
    localparam int WATCHDOG_CYCLES = TOTAL_OPS * 20 + 200;  // Worst case per op plus slack

    logic      g_clk = 1'b0;
    logic      rst_n;
    logic      in_valid;
    issue_op_t in_op;
    logic      in_ready;
    logic      trs_valid;
    retire_t   trs_rec;
    logic      trs_ready;

    integer    seed      = 32'h2d4ad134;
    logic      bp_enable = 1'b0;         // Random trace back-pressure on
    int        errors    = 0;
    int        n_checks  = 0;

    retire_t   exp_q [$];                // Expected records, program order
    string     name_q [$];               // Test name per record
    word_t     model_regs [NREGS];
    word_t     model_mem [DMEM_WORDS];
    issue_op_t rnd_ops [N_RANDOM];
    int        rnd_gaps [N_RANDOM];

    always #(CLK_PERIOD / 2) g_clk = ~g_clk;

    pipe_top u_pipe_top (
        .g_clk     (g_clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_op     (in_op),
        .in_ready  (in_ready),
        .trs_valid (trs_valid),
        .trs_rec   (trs_rec),
        .trs_ready (trs_ready)
    );

    // Reference model ------------------------
    function automatic retire_t model_exec(input issue_op_t op);
        retire_t            rec;
        word_t              a;
        word_t              b;
        word_t              imm;
        word_t              addr;
        word_t              res;
        logic [DMEM_AW-1:0] idx;
        a    = (op.rs1 == '0) ? '0 : model_regs[op.rs1];  // x0 reads zero
        b    = (op.rs2 == '0) ? '0 : model_regs[op.rs2];
        imm  = {{(XLEN - IMM_W){op.imm[IMM_W-1]}}, op.imm};
        addr = a + imm;
        idx  = addr[DMEM_AW+1:2];                          // Word index
        rec.uop = op.uop;
        rec.rd  = op.rd;
        case (op.uop)
            UOP_ADD:  res = a + b;
            UOP_SUB:  res = a - b;
            UOP_AND:  res = a & b;
            UOP_XOR:  res = a ^ b;
            UOP_ADDI: res = a + imm;
            UOP_LOAD: res = model_mem[idx];
            default: begin
                model_mem[idx] = b;                        // Store
                res    = b;
                rec.rd = '0;
            end
        endcase
        if (op.uop != UOP_STORE && op.rd != '0) begin
            model_regs[op.rd] = res;
        end
        rec.wdata = res;
        return rec;
    endfunction

    function automatic issue_op_t make_op(uop_e uop, int rd, int rs1, int rs2, int imm);
        issue_op_t op;
        op.uop = uop;
        op.rd  = reg_addr_t'(rd);
        op.rs1 = reg_addr_t'(rs1);
        op.rs2 = reg_addr_t'(rs2);
        op.imm = imm_t'(imm);
        return op;
    endfunction

    // Issue one op after gap idle cycles, return in the drive slot after it transfers
    task automatic send_op(input string name, input issue_op_t op, input int gap);
        if (gap > 0) begin
            in_valid = 1'b0;
            repeat (gap) begin
                @(posedge g_clk);
                #10;
            end
        end
        exp_q.push_back(model_exec(op));
        name_q.push_back(name);
        in_valid = 1'b1;
        in_op    = op;
        @(negedge g_clk);
        while (!in_ready) @(negedge g_clk);
        @(posedge g_clk);
        #10;
    endtask

    // Trace sink ------------------------------
    initial begin : ready_drive
        logic ready_next;
        forever begin
            @(posedge g_clk);
            // Mode taken at the edge, level driven after the hold delay
            if (bp_enable) begin
                ready_next = ($random(seed) % 4) != 0;  // Low about a quarter of cycles
            end else begin
                ready_next = 1'b1;
            end
            #10;
            trs_ready = ready_next;
        end
    end

    initial begin : compare
        retire_t exp_rec;
        string   exp_name;
        forever begin
            @(negedge g_clk);                          // Record stable mid-cycle
            if (rst_n && trs_valid && trs_ready) begin
                assert (exp_q.size() > 0) else begin
                    errors++;
                    $display("Trace record retired with no op outstanding: %h", trs_rec);
                end
                if (exp_q.size() > 0) begin
                    exp_rec  = exp_q.pop_front();
                    exp_name = name_q.pop_front();
                    n_checks++;
                    assert (trs_rec == exp_rec) else begin
                        errors++;
                        $display("MISMATCH %s: expected %s rd=%0d wdata=%h, actual %s rd=%0d wdata=%h",
                                 exp_name, exp_rec.uop.name(), exp_rec.rd, exp_rec.wdata,
                                 trs_rec.uop.name(), trs_rec.rd, trs_rec.wdata);
                    end
                end
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout after %0d cycles: %0d of %0d ops retired, %0d errors",
                 WATCHDOG_CYCLES, n_checks, TOTAL_OPS, errors);
        $display("Verification failed");
        $finish;
    end

    // Main sequence ---------------------------
    initial begin : stimulus
        int          asrt_errs;
        logic [2:0]  u;
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_op     = '0;
        trs_ready = 1'b1;
        for (int r = 0; r < NREGS; r++) begin
            model_regs[r] = '0;
        end
        for (int m = 0; m < DMEM_WORDS; m++) begin
            model_mem[m] = '0;
        end
        // Random program drawn up front
        for (int k = 0; k < N_RANDOM; k++) begin
            u = 3'($unsigned($random(seed)) % 7);
            rnd_ops[k] = make_op(uop_e'(u), $random(seed), $random(seed),
                                 $random(seed), $random(seed));
            if (rnd_ops[k].uop == UOP_LOAD || rnd_ops[k].uop == UOP_STORE) begin
                rnd_ops[k].imm = rnd_ops[k].imm & 16'h003c;  // Keep addresses close
                if ($random(seed) % 2 == 0) begin
                    rnd_ops[k].rs1 = '0;
                end
            end
            rnd_gaps[k] = ($unsigned($random(seed)) % 3 == 0) ?
                          int'($unsigned($random(seed)) % 4) : 0;
        end

        repeat (3) @(posedge g_clk);
        #10;
        rst_n = 1'b1;

        // Independent ALU ops
        send_op("alu_indep", make_op(UOP_ADDI, 1, 0, 0, 5), 0);
        send_op("alu_indep", make_op(UOP_ADDI, 2, 0, 0, -3), 0);
        send_op("alu_indep", make_op(UOP_ADDI, 3, 0, 0, 'h1234), 0);
        send_op("alu_indep", make_op(UOP_ADDI, 4, 0, 0, 'h0f0f), 0);
        send_op("alu_indep", make_op(UOP_ADDI, 5, 0, 0, 'h7fff), 0);
        send_op("alu_indep", make_op(UOP_ADDI, 6, 0, 0, 'h8001), 0);
        send_op("alu_indep", make_op(UOP_ADD, 7, 1, 2, 0), 0);
        send_op("alu_indep", make_op(UOP_SUB, 8, 3, 4, 0), 0);
        send_op("alu_indep", make_op(UOP_AND, 9, 5, 6, 0), 0);
        send_op("alu_indep", make_op(UOP_XOR, 10, 3, 6, 0), 0);
        // Each distance hits a different forwarding stage
        send_op("forward", make_op(UOP_ADD, 11, 1, 3, 0), 0);
        send_op("forward", make_op(UOP_ADD, 12, 11, 11, 0), 0);
        send_op("forward", make_op(UOP_SUB, 13, 12, 11, 0), 0);
        send_op("forward", make_op(UOP_XOR, 14, 11, 13, 0), 0);
        send_op("forward", make_op(UOP_ADDI, 15, 12, 0, 1), 0);
        // Load result used by the very next op
        send_op("load_use", make_op(UOP_STORE, 0, 0, 7, 8), 0);
        send_op("load_use", make_op(UOP_LOAD, 9, 0, 0, 8), 0);
        send_op("load_use", make_op(UOP_ADD, 10, 9, 1, 0), 0);
        send_op("load_use", make_op(UOP_LOAD, 11, 0, 0, 8), 0);
        send_op("load_use", make_op(UOP_SUB, 12, 1, 11, 0), 0);
        // Store then load, and a word never written
        send_op("store_load", make_op(UOP_ADDI, 3, 0, 0, 'h40), 0);
        send_op("store_load", make_op(UOP_STORE, 0, 3, 8, 4), 0);
        send_op("store_load", make_op(UOP_LOAD, 4, 3, 0, 4), 0);
        send_op("store_load", make_op(UOP_LOAD, 5, 0, 0, 60), 0);
        send_op("store_load", make_op(UOP_STORE, 0, 0, 14, 12), 0);
        send_op("store_load", make_op(UOP_LOAD, 6, 0, 0, 12), 0);
        // x0 stays zero even right behind a write to it
        send_op("reg_zero", make_op(UOP_ADDI, 0, 0, 0, 123), 0);
        send_op("reg_zero", make_op(UOP_ADD, 0, 1, 1, 0), 0);
        send_op("reg_zero", make_op(UOP_ADD, 1, 0, 0, 0), 0);
        send_op("reg_zero", make_op(UOP_ADDI, 2, 0, 0, 9), 0);

        bp_enable = 1'b1;
        for (int k = 0; k < N_RANDOM; k++) begin
            send_op("random", rnd_ops[k], rnd_gaps[k]);
        end
        in_valid  = 1'b0;
        bp_enable = 1'b0;

        while (exp_q.size() > 0) @(posedge g_clk);
        repeat (10) @(posedge g_clk);                  // Catch stray records

        asrt_errs = u_pipe_top.u_asserts.fail_cnt;
        $display("Records checked %0d of %0d, check errors %0d, assertion errors %0d",
                 n_checks, TOTAL_OPS, errors, asrt_errs);
        if (errors == 0 && asrt_errs == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
